//--- hw/data_mem_cfg.svh
`ifndef DATA_MEM_CFG_SVH
`define DATA_MEM_CFG_SVH

// width of the core's address bus
`define DATA_MEM_ADDR_WIDTH 32

// log2 of the memory size in bytes
`define DATA_MEM_SIZE_WIDTH 16

// byte lanes per word row
`define DATA_MEM_LANES 4
`define DATA_MEM_LANE_WIDTH 8

// row address of a single lane
`define DATA_MEM_ROW_WIDTH (`DATA_MEM_SIZE_WIDTH - 2)

`endif

//--- hw/data_mem_pkg.sv
`default_nettype none

`include "data_mem_cfg.svh"

package data_mem_pkg;

    // funct3 as seen by store instructions
    typedef enum logic [2:0] {
        SB = 3'd0,
        SH = 3'd1,
        SW = 3'd2
    } store_op_e;

    // funct3 as seen by load instructions
    typedef enum logic [2:0] {
        LB  = 3'd0,
        LH  = 3'd1,
        LW  = 3'd2,
        LBU = 3'd4,
        LHU = 3'd5
    } load_op_e;

    // one funct3 field, decoded by the store path or the load path
    typedef union packed {
        store_op_e store_op;
        load_op_e  load_op;
    } mem_funct_u;

    // single byte held by one lane
    typedef logic [`DATA_MEM_LANE_WIDTH-1:0] lane_byte_t;

    // word row index inside one lane
    typedef logic [`DATA_MEM_ROW_WIDTH-1:0] lane_row_t;

endpackage

`default_nettype wire

//--- hw/store_lane_decode.sv
`default_nettype none

`include "data_mem_cfg.svh"

module store_lane_decode (
    input  wire logic [`DATA_MEM_ADDR_WIDTH-1:0]                     address,
    input  wire logic [`DATA_MEM_LANES*`DATA_MEM_LANE_WIDTH-1:0]     data_in,
    input  wire logic                                                write,
    input  wire logic                                                read,
    input  wire data_mem_pkg::mem_funct_u                            funct3,
    output      data_mem_pkg::lane_byte_t [`DATA_MEM_LANES-1:0]      lane_data,
    output      data_mem_pkg::lane_row_t  [`DATA_MEM_LANES-1:0]      lane_row,
    output      logic [`DATA_MEM_LANES-1:0]                          lane_write,
    output      logic                                                fault
);

    localparam int AW = `DATA_MEM_ADDR_WIDTH;
    localparam int LW = `DATA_MEM_LANE_WIDTH;

    // one past the last valid byte address
    localparam logic [AW-1:0] MEM_BYTES = AW'(1) << `DATA_MEM_SIZE_WIDTH;

    logic [AW-1:0]               access_size;
    logic [2:0]                  store_bytes;
    logic [1:0]                  offset;
    data_mem_pkg::lane_row_t     base_row;

    assign offset   = address[1:0];
    assign base_row = address[`DATA_MEM_SIZE_WIDTH-1:2];

    // access size, store view when writing and load view when reading
    always_comb begin
        access_size = AW'(1);
        if (write) begin
            case (funct3.store_op)
                data_mem_pkg::SW: access_size = AW'(4);
                data_mem_pkg::SH: access_size = AW'(2);
                default:          access_size = AW'(1);
            endcase
        end else if (read) begin
            case (funct3.load_op)
                data_mem_pkg::LW:  access_size = AW'(4);
                data_mem_pkg::LH,
                data_mem_pkg::LHU: access_size = AW'(2);
                default:           access_size = AW'(1);
            endcase
        end
    end

    // last byte of the access must stay inside the memory
    assign fault = (read || write) && (address > MEM_BYTES - access_size);

    // bytes actually stored, none for unknown codes
    always_comb begin
        case (funct3.store_op)
            data_mem_pkg::SB: store_bytes = 3'd1;
            data_mem_pkg::SH: store_bytes = 3'd2;
            data_mem_pkg::SW: store_bytes = 3'd4;
            default:          store_bytes = 3'd0;
        endcase
    end

    // steer byte k to lane (offset + k) mod 4
    always_comb begin
        logic [2:0] pos;
        logic [1:0] lane;

        lane_data  = '0;
        lane_row   = '0;
        lane_write = '0;
        for (int k = 0; k < `DATA_MEM_LANES; k++) begin
            pos  = {1'b0, offset} + 3'(k);
            lane = pos[1:0];
            lane_data[lane] = data_in[k*LW +: LW];
            // wrapped store bytes land in the next row
            // loads stay on the current row for every lane
            lane_row[lane] = base_row + data_mem_pkg::lane_row_t'(write && pos[2]);
            lane_write[lane] = write && !fault && (3'(k) < store_bytes);
        end
    end

endmodule

`default_nettype wire

//--- hw/byte_lane_ram.sv
`default_nettype none

`include "data_mem_cfg.svh"

module byte_lane_ram (
    input  wire logic                     clk,
    input  wire data_mem_pkg::lane_row_t  row,
    input  wire logic                     write,
    input  wire data_mem_pkg::lane_byte_t wdata,
    output      data_mem_pkg::lane_byte_t rdata
);

    localparam int ROWS = 2 ** `DATA_MEM_ROW_WIDTH;

    // one byte column of the data memory, maps to block RAM
    data_mem_pkg::lane_byte_t mem [ROWS];

    // read-first, old contents come out on a write
    always_ff @(posedge clk) begin
        if (write) begin
            mem[row] <= wdata;
        end
        rdata <= mem[row];
    end

endmodule

`default_nettype wire

//--- hw/load_align.sv
`default_nettype none

`include "data_mem_cfg.svh"

module load_align (
    input  wire logic                                               clk,
    input  wire logic                                               rst,
    input  wire logic                                               read,
    input  wire logic                                               fault_in,
    input  wire logic [1:0]                                         offset,
    input  wire data_mem_pkg::mem_funct_u                           funct3,
    input  wire data_mem_pkg::lane_byte_t [`DATA_MEM_LANES-1:0]     lane_rdata,
    output      logic [`DATA_MEM_LANES*`DATA_MEM_LANE_WIDTH-1:0]    data_out,
    output      logic                                               fault
);

    localparam int DW = `DATA_MEM_LANES * `DATA_MEM_LANE_WIDTH;
    localparam int LW = `DATA_MEM_LANE_WIDTH;

    logic                                            read_q;
    logic                                            fault_q;
    logic [1:0]                                      offset_q;
    data_mem_pkg::mem_funct_u                        funct3_q;
    data_mem_pkg::lane_byte_t [`DATA_MEM_LANES-1:0]  rot;
    logic [DW-1:0]                                   word;
    logic [DW-1:0]                                   extended;

    // load control lines up with the RAM output
    always_ff @(posedge clk) begin
        if (rst) begin
            read_q   <= 1'b0;
            fault_q  <= 1'b0;
            offset_q <= 2'd0;
            funct3_q <= '0;
        end else begin
            read_q   <= read;
            fault_q  <= fault_in;
            offset_q <= offset;
            funct3_q <= funct3;
        end
    end

    // byte k of the result sits in lane (offset + k) mod 4
    always_comb begin
        for (int k = 0; k < `DATA_MEM_LANES; k++) begin
            rot[k] = lane_rdata[offset_q + 2'(k)];
        end
    end

    assign word = rot;

    // truncate, then sign or zero fill
    always_comb begin
        case (funct3_q.load_op)
            data_mem_pkg::LB:  extended = {{(DW-LW){word[LW-1]}}, word[LW-1:0]};
            data_mem_pkg::LBU: extended = {{(DW-LW){1'b0}}, word[LW-1:0]};
            data_mem_pkg::LH:  extended = {{(DW-2*LW){word[2*LW-1]}}, word[2*LW-1:0]};
            data_mem_pkg::LHU: extended = {{(DW-2*LW){1'b0}}, word[2*LW-1:0]};
            data_mem_pkg::LW:  extended = word;
            default:           extended = '0;
        endcase
    end

    // nothing comes back without a clean read
    assign data_out = (read_q && !fault_q) ? extended : '0;
    assign fault    = fault_q;

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`default_nettype none

`include "data_mem_cfg.svh"

module data_mem (
    input  wire logic                                            clk,
    input  wire logic                                            rst,
    input  wire logic [`DATA_MEM_ADDR_WIDTH-1:0]                 address,
    input  wire logic [`DATA_MEM_LANES*`DATA_MEM_LANE_WIDTH-1:0] data_in,
    input  wire logic                                            write,
    input  wire logic                                            read,
    input  wire data_mem_pkg::mem_funct_u                        funct3,
    output      logic [`DATA_MEM_LANES*`DATA_MEM_LANE_WIDTH-1:0] data_out,
    output      logic                                            fault
);

    data_mem_pkg::lane_byte_t [`DATA_MEM_LANES-1:0] lane_data;
    data_mem_pkg::lane_row_t  [`DATA_MEM_LANES-1:0] lane_row;
    logic [`DATA_MEM_LANES-1:0]                     lane_write;
    data_mem_pkg::lane_byte_t [`DATA_MEM_LANES-1:0] lane_rdata;
    logic                                           access_fault;

    // range check and byte steering for the current access
    store_lane_decode u_decode (
        .address    (address),
        .data_in    (data_in),
        .write      (write),
        .read       (read),
        .funct3     (funct3),
        .lane_data  (lane_data),
        .lane_row   (lane_row),
        .lane_write (lane_write),
        .fault      (access_fault)
    );

    // four byte columns, lane i holds byte i of each row
    for (genvar i = 0; i < `DATA_MEM_LANES; i++) begin : g_lane
        byte_lane_ram u_lane (
            .clk   (clk),
            .row   (lane_row[i]),
            .write (lane_write[i]),
            .wdata (lane_data[i]),
            .rdata (lane_rdata[i])
        );
    end

    // load result one cycle after the request
    load_align u_align (
        .clk        (clk),
        .rst        (rst),
        .read       (read),
        .fault_in   (access_fault),
        .offset     (address[1:0]),
        .funct3     (funct3),
        .lane_rdata (lane_rdata),
        .data_out   (data_out),
        .fault      (fault)
    );

endmodule

`default_nettype wire

//--- dv/data_mem_tb.sv
`default_nettype none

`include "data_mem_cfg.svh"

module data_mem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DW = `DATA_MEM_LANES * `DATA_MEM_LANE_WIDTH;
    localparam int AW = `DATA_MEM_ADDR_WIDTH;
    localparam int SIZE_W = `DATA_MEM_SIZE_WIDTH;
    localparam int MEM_BYTES = 2 ** `DATA_MEM_SIZE_WIDTH;
    localparam int MAX_CYCLES = 2000;
    localparam int RANDOM_ACCESSES = 600;
    localparam logic [AW-1:0] RANDOM_BASE = 32'h0000_0200;

    logic          clk;
    logic          rst;
    logic [AW-1:0] address;
    logic [DW-1:0] data_in;
    logic          write;
    logic          read;
    logic [2:0]    funct3;
    logic [DW-1:0] data_out;
    logic          fault;

    // reference byte array and one-cycle delayed expectation
    logic [7:0]    model_mem [MEM_BYTES];
    logic [DW-1:0] exp_data;
    logic          exp_fault;

    int            seed = 65;
    int            cycle_count;

    data_mem dut (
        .clk      (clk),
        .rst      (rst),
        .address  (address),
        .data_in  (data_in),
        .write    (write),
        .read     (read),
        .funct3   (funct3),
        .data_out (data_out),
        .fault    (fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // bytes touched by one access, store view while writing
    function automatic int access_size(input logic wr, input logic rd, input logic [2:0] code);
        if (wr) begin
            if (code == data_mem_pkg::SW) return 4;
            if (code == data_mem_pkg::SH) return 2;
            return 1;
        end
        if (rd) begin
            if (code == data_mem_pkg::LW) return 4;
            if (code == data_mem_pkg::LH || code == data_mem_pkg::LHU) return 2;
        end
        return 1;
    endfunction

    function automatic logic access_faults(input logic wr, input logic rd,
                                           input logic [2:0] code, input logic [AW-1:0] addr);
        int size;
        size = access_size(wr, rd, code);
        return (wr || rd) && (longint'(addr) > longint'(MEM_BYTES - size));
    endfunction

    // unknown store codes write no byte at all
    function automatic int store_count(input logic [2:0] code);
        case (code)
            data_mem_pkg::SB: return 1;
            data_mem_pkg::SH: return 2;
            data_mem_pkg::SW: return 4;
            default:          return 0;
        endcase
    endfunction

    task automatic apply_store(input logic [2:0] code, input logic [AW-1:0] addr,
                               input logic [DW-1:0] data);
        logic [SIZE_W-1:0] byte_addr;
        for (int k = 0; k < store_count(code); k++) begin
            byte_addr = addr[SIZE_W-1:0] + SIZE_W'(k);
            model_mem[byte_addr] = data[k*8 +: 8];
        end
    endtask

    // every lane reads the current row, even for a crossing load
    function automatic logic [DW-1:0] expected_load(input logic [2:0] code,
                                                    input logic [AW-1:0] addr);
        logic [DW-1:0] word;
        logic [1:0]    lane;
        for (int k = 0; k < 4; k++) begin
            lane = addr[1:0] + 2'(k);
            word[k*8 +: 8] = model_mem[{addr[SIZE_W-1:2], lane}];
        end
        case (code)
            data_mem_pkg::LB:  return {{24{word[7]}}, word[7:0]};
            data_mem_pkg::LBU: return {24'h0, word[7:0]};
            data_mem_pkg::LH:  return {{16{word[15]}}, word[15:0]};
            data_mem_pkg::LHU: return {16'h0, word[15:0]};
            data_mem_pkg::LW:  return word;
            default:           return '0;
        endcase
    endfunction

    // model update and expectation, both seen at the DUT's sampling edge
    always @(posedge clk) begin
        logic f;
        if (rst) begin
            exp_data  <= '0;
            exp_fault <= 1'b0;
        end else begin
            f = access_faults(write, read, funct3, address);
            if (write && !f) begin
                apply_store(funct3, address, data_in);
            end
            exp_fault <= f;
            exp_data  <= (read && !f) ? expected_load(funct3, address) : '0;
        end
    end

    // outputs compared mid-cycle where they are settled
    data_out_check: assert property (@(negedge clk) disable iff (rst) data_out == exp_data)
        else begin
            $display("MISMATCH at %0t ns: data_out is %h, expected %h",
                     $time, data_out, exp_data);
            $display("Test FAILED");
            $fatal(1, "data_out check failed");
        end

    fault_check: assert property (@(negedge clk) disable iff (rst) fault == exp_fault)
        else begin
            $display("MISMATCH at %0t ns: fault is %b, expected %b", $time, fault, exp_fault);
            $display("Test FAILED");
            $fatal(1, "fault check failed");
        end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the test did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    task automatic drive_access(input logic wr, input logic rd, input logic [2:0] code,
                                input logic [AW-1:0] addr, input logic [DW-1:0] data);
        @(posedge clk);
        write   <= wr;
        read    <= rd;
        funct3  <= code;
        address <= addr;
        data_in <= data;
    endtask

    task automatic store_at(input logic [2:0] code, input logic [AW-1:0] addr,
                            input logic [DW-1:0] data);
        drive_access(1'b1, 1'b0, code, addr, data);
    endtask

    task automatic load_at(input logic [2:0] code, input logic [AW-1:0] addr);
        drive_access(1'b0, 1'b1, code, addr, '0);
    endtask

    // idle cycles park the address out of range, no strobe means no fault
    task automatic idle_for(input int cycles);
        repeat (cycles) drive_access(1'b0, 1'b0, 3'd0, '1, '0);
    endtask

    // word pattern mixes every address bit
    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
        return {a[15:0] ^ a[31:16] ^ 16'hC35A, ~a[15:0]};
    endfunction

    task automatic fill_region(input logic [AW-1:0] start, input int words);
        logic [AW-1:0] a;
        for (int i = 0; i < words; i++) begin
            a = start + AW'(4 * i);
            store_at(data_mem_pkg::SW, a, fill_word(a));
        end
    endtask

    initial begin
        logic [AW-1:0] a;
        logic [31:0]   r;
        logic [DW-1:0] d;

        rst     <= 1'b1;
        address <= '0;
        data_in <= '0;
        write   <= 1'b0;
        read    <= 1'b0;
        funct3  <= 3'd0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idle_for(2);

        // every location that is read later gets a known value first
        fill_region(32'h0000_0000, 4);
        fill_region(32'h0000_0100, 8);
        fill_region(RANDOM_BASE, 16);
        fill_region(32'h0000_FFE0, 8);
        idle_for(1);

        // all offsets, SW and SH at offset 3 cross into the next row
        for (int off = 0; off < 4; off++) begin
            a = 32'h0000_0100 + AW'(9 * off);
            store_at(data_mem_pkg::SW, a, 32'h1122_3344 + DW'(off * 32'h0101_0101));
            load_at(data_mem_pkg::LW, a);
            load_at(data_mem_pkg::LW, {a[AW-1:2], 2'b00});
            load_at(data_mem_pkg::LW, {a[AW-1:2], 2'b00} + 32'd4);
            store_at(data_mem_pkg::SH, a, 32'h0000_A55A + DW'(off));
            load_at(data_mem_pkg::LHU, a);
            load_at(data_mem_pkg::LH, a);
            store_at(data_mem_pkg::SB, a, 32'h0000_0066 + DW'(off));
            load_at(data_mem_pkg::LBU, a);
            load_at(data_mem_pkg::LB, a);
            idle_for(1);
        end

        // top bits set in every byte
        store_at(data_mem_pkg::SW, 32'h0000_0110, 32'h8FF0_81C7);
        for (int off = 0; off < 4; off++) begin
            a = 32'h0000_0110 + AW'(off);
            load_at(data_mem_pkg::LB, a);
            load_at(data_mem_pkg::LBU, a);
            load_at(data_mem_pkg::LH, a);
            load_at(data_mem_pkg::LHU, a);
            load_at(data_mem_pkg::LW, a);
        end
        idle_for(1);

        // loads around the top of memory, every code
        for (int c = 0; c < 8; c++) begin
            for (a = 32'h0000_FFF8; a <= 32'h0001_0004; a++) begin
                load_at(3'(c), a);
            end
        end
        load_at(data_mem_pkg::LW, 32'hFFFF_FFFC);
        load_at(data_mem_pkg::LB, 32'hFFFF_FFFF);

        // stores around the top, read back at the same row and at the alias row
        for (int c = 0; c < 8; c++) begin
            for (a = 32'h0000_FFFA; a <= 32'h0001_0004; a++) begin
                store_at(3'(c), a, {16'hBEEF, a[15:0]} ^ DW'(c));
                load_at(data_mem_pkg::LW, 32'h0000_FFFC);
                load_at(data_mem_pkg::LW, {16'h0, a[15:2], 2'b00});
            end
        end
        store_at(data_mem_pkg::SB, 32'hFFFF_FFFF, 32'h0000_00AA);
        load_at(data_mem_pkg::LW, 32'h0000_FFFC);
        idle_for(1);

        // back-to-back random accesses in a small window
        for (int i = 0; i < RANDOM_ACCESSES; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = RANDOM_BASE + AW'(r[5:0]);
            case (r[10:9])
                2'd0:    idle_for(1);
                2'd1:    store_at(r[8:6], a, d);
                default: load_at(r[8:6], a);
            endcase
        end

        idle_for(3);
        @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- data_mem.f
+incdir+hw
hw/data_mem_pkg.sv
hw/store_lane_decode.sv
hw/byte_lane_ram.sv
hw/load_align.sv
hw/data_mem.sv
dv/data_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the data memory testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module data_mem_tb \
    -f data_mem.f -o sim_data_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_data_mem 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
